// File: src/readout_pkg.sv
// readout widths, depths, channel types, word structs and serializer state enum
package readout_pkg;

    localparam int NUM_CH = 6;  // four front ends, tdc, trigger
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int BYTES_PER_WORD = 4;  // WORD_W / BYTE_W
    localparam int CH_DEPTH = 8;  // also initial source credit
    localparam int OUT_DEPTH = 16;
    localparam int TRIG_CH = 0;  // trigger channel, may request hold

    localparam int CH_PTR_W = $clog2(CH_DEPTH);  // depths are powers of two
    localparam int CH_CNT_W = $clog2(CH_DEPTH + 1);
    localparam int OUT_PTR_W = $clog2(OUT_DEPTH);
    localparam int OUT_CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int BYTE_IDX_W = $clog2(BYTES_PER_WORD);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [NUM_CH-1:0] ch_mask_t;  // enables, requests, grants
    typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;  // 3 bits
    typedef logic [7:0] credit_cnt_t;  // downstream byte credits

    // source to channel buffer
    typedef struct packed {
        logic  valid;  // spends one source credit
        word_t data;
    } src_word_t;

    // arbiter register to shared buffer
    typedef struct packed {
        logic  valid;
        word_t data;
    } arb_word_t;

    typedef enum logic {
        ser_idle,  // no word loaded
        ser_send   // bytes of a word going out
    } ser_state_e;

endpackage

// File: src/channel_ingest.sv
// channel word buffer with head output, non-empty flag and per-pop credit return
`timescale 1ns/100ps

module channel_ingest (
    input  logic                    CLK40,
    input  logic                    i_rst,
    input  readout_pkg::src_word_t  i_src,      // word from source, credit guarded
    input  logic                    i_pop,      // one-hot grant bit from arbiter
    output logic                    o_nonempty,
    output readout_pkg::word_t      o_head,     // oldest word, valid while nonempty
    output logic                    o_credit    // one pulse per popped word
);

    readout_pkg::word_t                  mem [readout_pkg::CH_DEPTH];  // payload store
    logic [readout_pkg::CH_PTR_W-1:0]    wr_ptr;
    logic [readout_pkg::CH_PTR_W-1:0]    rd_ptr;
    logic [readout_pkg::CH_CNT_W-1:0]    fill_cnt;  // 0 .. CH_DEPTH
    logic                                push;
    logic                                pop;

    assign push = i_src.valid;  // source never pushes without a credit
    assign pop  = i_pop & o_nonempty;  // arbiter only grants non-empty channels

    // write side
    always_ff @(posedge CLK40) begin
        if (push) begin
            mem[wr_ptr] <= i_src.data;
        end
    end

    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at CH_DEPTH
        end
    end

    // read side
    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // fill level, push and pop in one cycle cancel out
    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            fill_cnt <= '0;
        end else begin
            case ({push, pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // credit goes back the cycle after the pop
    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            o_credit <= 1'b0;
        end else begin
            o_credit <= pop;
        end
    end

    assign o_nonempty = (fill_cnt != '0);  // registered count, push at N shows at N+1
    assign o_head     = mem[rd_ptr];  // first word fall through

endmodule

// File: src/readout_arbiter.sv
// round-robin channel arbiter with trigger hold priority and registered word output
`timescale 1ns/100ps

module readout_arbiter (
    input  logic                                               CLK40,
    input  logic                                               i_rst,
    input  readout_pkg::ch_mask_t                              i_nonempty,
    input  readout_pkg::ch_mask_t                              i_enable,     // channel mask
    input  logic                                               i_trig_hold,  // trigger first
    input  readout_pkg::word_t [readout_pkg::NUM_CH-1:0]       i_heads,
    input  logic                                               i_ready,      // buffer room
    output readout_pkg::ch_mask_t                              o_pop,        // one-hot
    output readout_pkg::arb_word_t                             o_word
);

    readout_pkg::ch_mask_t  req;          // enabled and non-empty
    readout_pkg::ch_idx_t   last_grant;   // round-robin pointer
    readout_pkg::ch_idx_t   grant_idx;
    logic                   grant_found;
    logic                   grant_valid;  // found and buffer has room
    logic                   word_valid_q;
    readout_pkg::word_t     word_data_q;

    assign req = i_nonempty & i_enable;

    // pick winner, trigger hold beats round robin
    always_comb begin : grant_sel
        int unsigned cand;
        cand        = 0;
        grant_found = 1'b0;
        grant_idx   = last_grant;
        if (i_trig_hold && req[readout_pkg::TRIG_CH]) begin
            grant_found = 1'b1;
            grant_idx   = readout_pkg::ch_idx_t'(readout_pkg::TRIG_CH);
        end else begin
            // search from the channel after the last winner, wrapping
            for (int ofs = 1; ofs <= readout_pkg::NUM_CH; ofs++) begin
                cand = (int'(last_grant) + ofs) % readout_pkg::NUM_CH;
                if (!grant_found && req[cand]) begin
                    grant_found = 1'b1;
                    grant_idx   = readout_pkg::ch_idx_t'(cand);
                end
            end
        end
    end

    assign grant_valid = grant_found & i_ready;  // no grant while buffer is short of room
    assign o_pop = grant_valid ? (readout_pkg::ch_mask_t'(1) << grant_idx) : '0;

    // remember winner for next search
    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            last_grant <= readout_pkg::ch_idx_t'(readout_pkg::NUM_CH - 1);  // ch 0 first
        end else if (grant_valid) begin
            last_grant <= grant_idx;
        end
    end

    // popped head shows up one cycle later
    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= grant_valid;
        end
    end

    always_ff @(posedge CLK40) begin
        if (grant_valid) begin
            word_data_q <= i_heads[grant_idx];
        end
    end

    assign o_word.valid = word_valid_q;
    assign o_word.data  = word_data_q;

endmodule

// File: src/word_to_byte_buffer.sv
// shared output word FIFO, word to byte serializer and downstream credit counter
`timescale 1ns/100ps

module word_to_byte_buffer (
    input  logic                    CLK40,
    input  logic                    i_rst,
    input  readout_pkg::arb_word_t  i_word,       // issued only while ready was high
    input  logic                    i_tx_credit,  // one byte granted per pulse
    output logic                    o_ready,      // room for word in flight plus one
    output logic                    o_tx_valid,
    output readout_pkg::byte_t      o_tx_byte
);

    readout_pkg::word_t                   mem [readout_pkg::OUT_DEPTH];
    logic [readout_pkg::OUT_PTR_W-1:0]    wr_ptr;
    logic [readout_pkg::OUT_PTR_W-1:0]    rd_ptr;
    logic [readout_pkg::OUT_CNT_W-1:0]    fill_cnt;
    logic                                 fifo_nonempty;
    logic                                 fifo_push;
    logic                                 fifo_pop;

    readout_pkg::ser_state_e              ser_state;
    readout_pkg::word_t                   ser_word;   // shifts right one byte per send
    logic [readout_pkg::BYTE_IDX_W-1:0]   byte_idx;
    logic                                 last_byte;
    logic                                 tx_fire;

    readout_pkg::credit_cnt_t             credit_cnt;
    logic                                 credit_max;

    assign fifo_push     = i_word.valid;
    assign fifo_nonempty = (fill_cnt != '0);
    assign o_ready = (fill_cnt <= readout_pkg::OUT_CNT_W'(readout_pkg::OUT_DEPTH - 2));

    // word store
    always_ff @(posedge CLK40) begin
        if (fifo_push) begin
            mem[wr_ptr] <= i_word.data;
        end
    end

    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo_push, fifo_pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // serializer
    assign tx_fire   = (ser_state == readout_pkg::ser_send) && (credit_cnt != '0);
    assign last_byte = (byte_idx == readout_pkg::BYTE_IDX_W'(readout_pkg::BYTES_PER_WORD - 1));
    // load when idle or right after the last byte so words follow without a bubble
    assign fifo_pop  = fifo_nonempty &&
                       ((ser_state == readout_pkg::ser_idle) || (tx_fire && last_byte));

    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            ser_state <= readout_pkg::ser_idle;
            byte_idx  <= '0;
        end else if (fifo_pop) begin
            ser_state <= readout_pkg::ser_send;  // next word loaded
            byte_idx  <= '0;
        end else if (tx_fire) begin
            byte_idx <= byte_idx + 1'b1;
            if (last_byte) begin
                ser_state <= readout_pkg::ser_idle;  // fifo ran dry
            end
        end
    end

    always_ff @(posedge CLK40) begin
        if (fifo_pop) begin
            ser_word <= mem[rd_ptr];
        end else if (tx_fire) begin
            ser_word <= ser_word >> readout_pkg::BYTE_W;  // lsb first
        end
    end

    assign o_tx_valid = tx_fire;
    assign o_tx_byte  = ser_word[readout_pkg::BYTE_W-1:0];

    // downstream credits count up per pulse and down per byte
    assign credit_max = (credit_cnt == '1);  // pulses past full range are dropped

    always_ff @(posedge CLK40) begin
        if (i_rst) begin
            credit_cnt <= '0;
        end else begin
            case ({i_tx_credit && !credit_max, tx_fire})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// File: src/readout_top.sv
// readout top level with six channel buffers, arbiter and word to byte output buffer
`timescale 1ns/100ps

module readout_top (
    input  logic                                               CLK40,
    input  logic                                               i_rst,
    input  readout_pkg::src_word_t [readout_pkg::NUM_CH-1:0]   i_src,
    input  readout_pkg::ch_mask_t                              i_enable,
    input  logic                                               i_trig_hold,
    input  logic                                               i_tx_credit,
    output readout_pkg::ch_mask_t                              o_credit,   // per source
    output logic                                               o_tx_valid,
    output readout_pkg::byte_t                                 o_tx_byte
);

    readout_pkg::ch_mask_t                          ch_nonempty;
    readout_pkg::ch_mask_t                          ch_pop;      // one-hot from arbiter
    readout_pkg::word_t [readout_pkg::NUM_CH-1:0]   ch_heads;
    readout_pkg::arb_word_t                         arb_word;
    logic                                           out_ready;

    // input side, one buffer per source
    for (genvar ch = 0; ch < readout_pkg::NUM_CH; ch++) begin : g_ch
        channel_ingest i_ingest (
            .CLK40      (CLK40),
            .i_rst      (i_rst),
            .i_src      (i_src[ch]),
            .i_pop      (ch_pop[ch]),
            .o_nonempty (ch_nonempty[ch]),
            .o_head     (ch_heads[ch]),
            .o_credit   (o_credit[ch])
        );
    end

    readout_arbiter i_arbiter (
        .CLK40       (CLK40),
        .i_rst       (i_rst),
        .i_nonempty  (ch_nonempty),
        .i_enable    (i_enable),
        .i_trig_hold (i_trig_hold),
        .i_heads     (ch_heads),
        .i_ready     (out_ready),
        .o_pop       (ch_pop),
        .o_word      (arb_word)
    );

    // output side toward network
    word_to_byte_buffer i_out_buf (
        .CLK40       (CLK40),
        .i_rst       (i_rst),
        .i_word      (arb_word),
        .i_tx_credit (i_tx_credit),
        .o_ready     (out_ready),
        .o_tx_valid  (o_tx_valid),
        .o_tx_byte   (o_tx_byte)
    );

endmodule

// File: testbench/tb_readout.sv
// readout testbench with clock, reset, source credit model, byte monitor and directed tests
`timescale 1ns/100ps

module tb_readout;

    logic                                               CLK40;
    logic                                               i_rst;
    readout_pkg::src_word_t [readout_pkg::NUM_CH-1:0]   i_src;
    readout_pkg::ch_mask_t                              i_enable;
    logic                                               i_trig_hold;
    logic                                               i_tx_credit;
    readout_pkg::ch_mask_t                              o_credit;
    logic                                               o_tx_valid;
    readout_pkg::byte_t                                 o_tx_byte;

    readout_pkg::word_t  exp_q [readout_pkg::NUM_CH][$];  // words in flight per channel
    int                  src_credit [readout_pkg::NUM_CH];  // credits each source holds
    int                  credit_pulses [readout_pkg::NUM_CH];
    int                  pushed [readout_pkg::NUM_CH];
    int                  arrive_log [$];  // channel tag of each word received
    readout_pkg::byte_t  byte_log [$];
    readout_pkg::word_t  rx_word;  // word being assembled
    int                  rx_count;  // bytes of rx_word so far
    int                  bytes_seen;
    int                  tx_outstanding;  // granted downstream but not yet spent
    bit                  free_credit;  // grant bytes as needed
    logic [31:0]         rng_state;
    int                  checks;
    int                  errors;
    bit                  timed_out;

    readout_top i_dut (
        .CLK40       (CLK40),
        .i_rst       (i_rst),
        .i_src       (i_src),
        .i_enable    (i_enable),
        .i_trig_hold (i_trig_hold),
        .i_tx_credit (i_tx_credit),
        .o_credit    (o_credit),
        .o_tx_valid  (o_tx_valid),
        .o_tx_byte   (o_tx_byte)
    );

    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;  // 4 ns period
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // channel index in the top three bits above a random payload
    function automatic readout_pkg::word_t make_word(input int ch);
        logic [31:0] r;
        r = next_random();
        return {readout_pkg::ch_idx_t'(ch), r[28:0]};
    endfunction

    function automatic int pending_bytes();
        int n;
        n = 0;
        for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
            n += exp_q[ch].size();
        end
        return n * readout_pkg::BYTES_PER_WORD - rx_count;  // partial word already counted
    endfunction

    function automatic bit all_drained(input readout_pkg::ch_mask_t mask);
        bit empty;
        empty = 1'b1;
        for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
            if (mask[ch] && exp_q[ch].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // advance to 1 ns past the next edge and grant credit only for bytes still owed
    task automatic step();
        @(posedge CLK40);
        #1;
        i_tx_credit = free_credit && (tx_outstanding < 8) && (tx_outstanding < pending_bytes());
    endtask

    // assemble output bytes lsb first and match each word to its tagged channel queue
    always @(posedge CLK40) begin : byte_monitor
        int ch;
        if (!i_rst) begin
            if (o_tx_valid) begin
                check_equal(tx_outstanding > 0, 1, "downstream credit held for byte");
                tx_outstanding--;
                bytes_seen++;
                byte_log.push_back(o_tx_byte);
                rx_word[rx_count*readout_pkg::BYTE_W +: readout_pkg::BYTE_W] = o_tx_byte;
                rx_count++;
                if (rx_count == readout_pkg::BYTES_PER_WORD) begin
                    rx_count = 0;
                    ch = int'(rx_word[readout_pkg::WORD_W-1 -: 3]);
                    arrive_log.push_back(ch);
                    check_equal(ch < readout_pkg::NUM_CH, 1, "channel tag in word");
                    if (ch < readout_pkg::NUM_CH) begin
                        check_equal(exp_q[ch].size() > 0, 1, "word expected on tagged channel");
                        if (exp_q[ch].size() > 0) begin
                            check_equal(rx_word, exp_q[ch].pop_front(), "word order in channel");
                        end
                    end
                end
            end
            if (i_tx_credit) begin
                tx_outstanding++;  // counted by the dut at this edge
            end
        end
    end

    // credit returns to the sources
    always @(posedge CLK40) begin
        if (!i_rst) begin
            for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
                if (o_credit[ch]) begin
                    src_credit[ch]++;
                    credit_pulses[ch]++;
                end
            end
        end
    end

    task automatic push_word(input int ch, input readout_pkg::word_t data);
        int cycles;
        cycles = 0;
        while (src_credit[ch] == 0 && !timed_out) begin  // push waits for a source credit
            if (cycles >= 2000) begin
                $display("timeout: source %0d got no credit back", ch);
                timed_out = 1'b1;
            end else begin
                step();
                cycles++;
            end
        end
        if (!timed_out) begin
            i_src[ch].valid = 1'b1;
            i_src[ch].data  = data;
            src_credit[ch]--;
            exp_q[ch].push_back(data);
            pushed[ch]++;
            step();
            i_src[ch] = '0;
        end
    endtask

    task automatic wait_until_drained(input readout_pkg::ch_mask_t mask, input int limit,
                                      input string what);
        int cycles;
        cycles = 0;
        while (!all_drained(mask) && !timed_out) begin
            if (cycles >= limit) begin
                $display("timeout: words still missing after %0d cycles (%s)", cycles, what);
                timed_out = 1'b1;
            end else begin
                step();
                cycles++;
            end
        end
    endtask

    task automatic send_one_word();
        readout_pkg::word_t w;
        int pulses_before;
        pulses_before = credit_pulses[3];
        byte_log.delete();
        free_credit = 1'b1;
        w = make_word(3);
        push_word(3, w);
        wait_until_drained('1, 200, "single word");
        if (timed_out) return;
        check_equal(byte_log.size(), readout_pkg::BYTES_PER_WORD, "bytes for one word");
        for (int b = 0; b < byte_log.size() && b < readout_pkg::BYTES_PER_WORD; b++) begin
            check_equal(byte_log[b], w[b*readout_pkg::BYTE_W +: readout_pkg::BYTE_W], "byte");
        end
        check_equal(credit_pulses[3] - pulses_before, 1, "credit pulses on channel 3");
        check_equal(src_credit[3], readout_pkg::CH_DEPTH, "channel 3 credits back");
    endtask

    task automatic mix_all_channels();
        int pulses_before [readout_pkg::NUM_CH];
        int pushed_before [readout_pkg::NUM_CH];
        int start;
        int ch;
        for (int c = 0; c < readout_pkg::NUM_CH; c++) begin
            pulses_before[c] = credit_pulses[c];
            pushed_before[c] = pushed[c];
        end
        free_credit = 1'b1;
        repeat (8) begin
            start = int'(next_random() % readout_pkg::NUM_CH);  // random rotation per round
            for (int k = 0; k < readout_pkg::NUM_CH; k++) begin
                ch = (start + k) % readout_pkg::NUM_CH;
                push_word(ch, make_word(ch));
            end
        end
        wait_until_drained('1, 2000, "random words on all channels");
        if (timed_out) return;
        for (int c = 0; c < readout_pkg::NUM_CH; c++) begin
            check_equal(credit_pulses[c] - pulses_before[c], pushed[c] - pushed_before[c],
                        "credit pulses equal words pushed");
        end
    endtask

    task automatic mask_channel_five();
        free_credit = 1'b1;
        i_enable = ~(readout_pkg::ch_mask_t'(1) << 5);  // channel 5 off
        repeat (4) begin
            for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
                push_word(ch, make_word(ch));
            end
        end
        wait_until_drained(~(readout_pkg::ch_mask_t'(1) << 5), 1000, "enabled channels");
        if (timed_out) return;
        check_equal(exp_q[5].size(), 4, "channel 5 words held while disabled");
        i_enable = '1;
        wait_until_drained('1, 500, "channel 5 after enable");
    endtask

    task automatic hold_for_trigger();
        int last_trig;
        int first_other;
        free_credit = 1'b0;
        arrive_log.delete();
        i_enable = 6'b111000;  // keep the words in the channel buffers while filling
        for (int k = 0; k < readout_pkg::CH_DEPTH; k++) begin
            for (int ch = 0; ch < 3; ch++) begin
                push_word(ch, make_word(ch));
            end
        end
        i_trig_hold = 1'b1;
        step();
        i_enable = '1;
        step();
        free_credit = 1'b1;  // now let bytes out
        wait_until_drained('1, 1000, "trigger hold drain");
        i_trig_hold = 1'b0;
        if (timed_out) return;
        last_trig   = -1;
        first_other = arrive_log.size();
        for (int i = 0; i < arrive_log.size(); i++) begin
            if (arrive_log[i] == readout_pkg::TRIG_CH) begin
                last_trig = i;
            end else if (first_other == arrive_log.size()) begin
                first_other = i;
            end
        end
        check_equal(arrive_log.size(), 3 * readout_pkg::CH_DEPTH, "words under trigger hold");
        check_equal(last_trig < first_other, 1, "trigger words ahead of channels 1 and 2");
    endtask

    task automatic stall_and_drain();
        int idle;
        int guard;
        int cycles;
        int gap;
        int start_bytes;
        bit pushed_one;
        free_credit = 1'b0;
        start_bytes = bytes_seen;
        idle  = 0;
        guard = 0;
        while (idle < 20 && !timed_out) begin  // stop once no source regains credit
            pushed_one = 1'b0;
            for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
                if (!pushed_one && src_credit[ch] > 0) begin
                    push_word(ch, make_word(ch));
                    pushed_one = 1'b1;
                end
            end
            if (pushed_one) begin
                idle = 0;
            end else begin
                step();
                idle++;
            end
            guard++;
            if (guard >= 1000) begin
                $display("timeout: sources kept getting credit with the output stalled");
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;
        check_equal(bytes_seen - start_bytes, 0, "bytes sent with no downstream credit");
        for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
            check_equal(src_credit[ch], 0, "source credits used up");
        end
        cycles = 0;
        while (!all_drained('1) && !timed_out) begin  // one credit followed by a random gap
            if (cycles >= 5000) begin
                $display("timeout: stalled words not drained with single credits");
                timed_out = 1'b1;
            end else begin
                i_tx_credit = 1'b1;
                step();
                gap = int'(next_random() % 4);
                repeat (gap) step();
                cycles += gap + 1;
            end
        end
        if (timed_out) return;
        for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
            check_equal(src_credit[ch], readout_pkg::CH_DEPTH, "source credits restored");
        end
    endtask

    task automatic run_tests();
        check_equal(o_tx_valid, 0, "tx valid after reset");
        check_equal(o_credit, 0, "credit pulses after reset");
        send_one_word();
        if (!timed_out) mix_all_channels();
        if (!timed_out) mask_channel_five();
        if (!timed_out) hold_for_trigger();
        if (!timed_out) stall_and_drain();
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        i_rst          = 1'b1;
        i_src          = '0;
        i_enable       = '1;
        i_trig_hold    = 1'b0;
        i_tx_credit    = 1'b0;
        rng_state      = 32'hf21a87f8;
        rx_word        = '0;
        rx_count       = 0;
        bytes_seen     = 0;
        tx_outstanding = 0;
        free_credit    = 1'b0;
        checks         = 0;
        errors         = 0;
        timed_out      = 1'b0;
        for (int ch = 0; ch < readout_pkg::NUM_CH; ch++) begin
            src_credit[ch]    = readout_pkg::CH_DEPTH;  // one per channel slot
            credit_pulses[ch] = 0;
            pushed[ch]        = 0;
        end
        repeat (5) @(posedge CLK40);
        #1;
        i_rst = 1'b0;
        run_tests();
        finish_run();
    end

endmodule

// File: compile.f
src/readout_pkg.sv
src/channel_ingest.sv
src/readout_arbiter.sv
src/word_to_byte_buffer.sv
src/readout_top.sv
testbench/tb_readout.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the readout testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_readout \
    -f compile.f \
    -o tb_readout

./obj_dir/tb_readout | tee "$LOG"

if grep -qx "TEST OK" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
